//--- verilog/frag_pkg.sv
// Shared definitions for the PCIe transmit fragmenter.
// Holds the beat and entry widths, the TLP header field positions,
// the ECRC polynomial and seed, and the packet state encoding.
// Every design file pulls what it needs from here.

package frag_pkg;

    // Dword and entry geometry
    localparam int DW_WIDTH = 32;
    localparam int ENTRY_DW = 4;

    typedef logic [DW_WIDTH-1:0] dword_t;

    // Dword 0 sits in the top bits
    typedef logic [ENTRY_DW*DW_WIDTH-1:0] entry_t;

    // Valid dwords in an entry, minus one
    typedef logic [$clog2(ENTRY_DW)-1:0] dw_count_t;

    // Valid bytes in a beat, minus one
    typedef logic [3:0] valid_bytes_t;

    // Header, data and ECRC dwords as seen by the DLL
    typedef logic [10:0] dll_length_t;

    // Header fields, all in dword 0 of the first entry
    localparam int HDR_FMT_HI = 31;
    localparam int HDR_FMT_LO = 29;
    localparam int HDR_TD_BIT = 15;
    localparam int HDR_LEN_HI = 9;
    localparam int HDR_LEN_LO = 0;

    // CRC-32, non-reflected, MSB first
    localparam dword_t ECRC_POLY = 32'h04C1_1DB7;
    localparam dword_t ECRC_SEED = 32'hFFFF_FFFF;

    // Packet progress in the sequencer
    typedef enum logic [1:0] {
        FRAG_IDLE,
        FRAG_STREAM,
        FRAG_ECRC_TAIL
    } frag_state_t;

endpackage

//--- verilog/frag_beat_if.sv
// Per-cycle beat control from the sequencer.
// The ECRC engine and the beat assembler watch it to know which
// cycles carry an entry, where a packet starts and ends, and when
// the ECRC-only beat is due.

`timescale 1ns/1ns

interface frag_beat_if;
    import frag_pkg::*;

    logic        entry_valid;
    logic        first;
    logic        last;
    logic        ecrc_on;
    logic        tail;
    dll_length_t length;

    modport seq (
        output entry_valid, first, last, ecrc_on, tail, length
    );

    // CRC only needs to know when to seed and when to run
    modport ecrc (
        input entry_valid, first, ecrc_on
    );

    modport asm (
        input entry_valid, first, last, ecrc_on, tail, length
    );

endinterface

//--- verilog/frag_sequencer.sv
// Read control and packet tracking for the fragmenter.
// Issues one FIFO read per cycle while data is available and halt is
// low, follows each packet from its first to its last entry, decodes
// the header and works out the DLL length. When a TD packet ends on a
// full entry it skips one read so the ECRC-only beat has a free slot.

`timescale 1ns/1ns

module frag_sequencer (
    input  logic                clk,
    input  logic                arst,
    input  logic                fifo_empty,
    input  logic                halt,
    input  frag_pkg::entry_t    fifo_rd_data,
    input  frag_pkg::dw_count_t fifo_rd_dw,
    input  logic                fifo_rd_last,
    output logic                fifo_rd_en,
    frag_beat_if.seq            beat
);
    import frag_pkg::*;

    frag_state_t state;
    frag_state_t state_nx;

    // High in the cycle an entry is on fifo_rd_data
    logic rd_in_flight;

    // Values held for the rest of the packet
    logic        td_q;
    dll_length_t len_q;

    // Header decode of the entry on the bus
    dword_t                           dw0;
    logic [HDR_FMT_HI-HDR_FMT_LO:0]   fmt;
    logic [HDR_LEN_HI-HDR_LEN_LO:0]   len_field;
    logic                             td_dec;
    dll_length_t                      len_calc;

    logic        is_first;
    logic        td_cur;
    dll_length_t len_cur;
    logic        need_tail;

    assign dw0       = fifo_rd_data[ENTRY_DW*DW_WIDTH-1 -: DW_WIDTH];
    assign fmt       = dw0[HDR_FMT_HI:HDR_FMT_LO];
    assign len_field = dw0[HDR_LEN_HI:HDR_LEN_LO];
    assign td_dec    = dw0[HDR_TD_BIT];

    // 3DW or 4DW header, then payload, then the ECRC dword
    always_comb begin
        len_calc = dll_length_t'(3);
        if (fmt[0]) begin
            len_calc = len_calc + dll_length_t'(1);
        end
        if (fmt[1]) begin
            // A zero length field means 1024 dwords
            if (len_field == '0) begin
                len_calc = len_calc + dll_length_t'(1024);
            end else begin
                len_calc = len_calc + dll_length_t'(len_field);
            end
        end
        if (td_dec) begin
            len_calc = len_calc + dll_length_t'(1);
        end
    end

    // Any entry that arrives outside an open packet starts one
    assign is_first = rd_in_flight && (state != FRAG_STREAM);
    assign td_cur   = is_first ? td_dec : td_q;
    assign len_cur  = is_first ? len_calc : len_q;

    // Last entry of a TD packet with all four dwords used
    assign need_tail = rd_in_flight && fifo_rd_last && td_cur && (fifo_rd_dw == 2'd3);

    assign fifo_rd_en = !fifo_empty && !halt && !need_tail;

    always_comb begin
        state_nx = state;
        case (state)
            FRAG_IDLE, FRAG_STREAM: begin
                if (rd_in_flight) begin
                    if (!fifo_rd_last) begin
                        state_nx = FRAG_STREAM;
                    end else if (need_tail) begin
                        state_nx = FRAG_ECRC_TAIL;
                    end else begin
                        state_nx = FRAG_IDLE;
                    end
                end
            end
            // Single cycle for the ECRC-only beat
            FRAG_ECRC_TAIL: begin
                state_nx = FRAG_IDLE;
            end
            default: begin
                state_nx = FRAG_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            state        <= FRAG_IDLE;
            rd_in_flight <= 1'b0;
            td_q         <= 1'b0;
        end else begin
            state        <= state_nx;
            rd_in_flight <= fifo_rd_en;
            if (is_first) begin
                td_q <= td_dec;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_first) begin
            len_q <= len_calc;
        end
    end

    assign beat.entry_valid = rd_in_flight;
    assign beat.first       = is_first;
    assign beat.last        = rd_in_flight && fifo_rd_last;
    assign beat.ecrc_on     = td_cur;
    assign beat.tail        = (state == FRAG_ECRC_TAIL);
    assign beat.length      = len_cur;

endmodule

//--- verilog/ecrc_engine.sv
// End-to-end CRC for TD packets.
// Runs the valid dwords of each entry through CRC-32, dword 0 first,
// seeding on the first entry of a packet. The inverted result is
// offered every cycle; outside entry cycles it comes from the stored
// value, which is what the ECRC-only beat picks up.

`timescale 1ns/1ns

module ecrc_engine (
    input  logic                clk,
    input  logic                arst,
    input  frag_pkg::entry_t    fifo_rd_data,
    input  frag_pkg::dw_count_t fifo_rd_dw,
    frag_beat_if.ecrc           beat,
    output frag_pkg::dword_t    ecrc_value
);
    import frag_pkg::*;

    dword_t crc_q;
    dword_t crc_next;

    // One dword through the CRC, most significant bit first
    function automatic dword_t crc_dword(input dword_t crc_in, input dword_t data);
        dword_t crc;
        logic   fb;
        crc = crc_in;
        for (int b = DW_WIDTH - 1; b >= 0; b--) begin
            fb  = crc[DW_WIDTH-1] ^ data[b];
            crc = {crc[DW_WIDTH-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ ECRC_POLY;
            end
        end
        return crc;
    endfunction

    always_comb begin : crc_comb
        dword_t crc_run;
        crc_run = beat.first ? ECRC_SEED : crc_q;
        for (int i = 0; i < ENTRY_DW; i++) begin
            // Skip dwords past the valid count
            if (i <= int'(fifo_rd_dw)) begin
                crc_run = crc_dword(crc_run,
                                    fifo_rd_data[(ENTRY_DW-i)*DW_WIDTH-1 -: DW_WIDTH]);
            end
        end
        crc_next = crc_run;
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            crc_q <= ECRC_SEED;
        end else if (beat.entry_valid && beat.ecrc_on) begin
            crc_q <= crc_next;
        end
    end

    // Tail cycle has no entry, so the stored value applies
    assign ecrc_value = ~(beat.entry_valid ? crc_next : crc_q);

endmodule

//--- verilog/beat_assembler.sv
// Builds the registered beats handed to the DLL.
// Each entry cycle or ECRC tail cycle becomes one beat a clock later.
// On the last entry of a TD packet the ECRC lands in the dword right
// after the valid ones, unless the entry is full; then the sequencer
// opens a tail cycle and the ECRC goes out alone in dword 0.

`timescale 1ns/1ns

module beat_assembler (
    input  logic                   clk,
    input  logic                   arst,
    input  frag_pkg::entry_t       fifo_rd_data,
    input  frag_pkg::dw_count_t    fifo_rd_dw,
    frag_beat_if.asm               beat,
    input  frag_pkg::dword_t       ecrc_value,
    output logic                   tlp_valid,
    output logic                   tlp_sop,
    output logic                   tlp_eop,
    output frag_pkg::entry_t       tlp_data,
    output frag_pkg::valid_bytes_t tlp_valid_bytes,
    output frag_pkg::dll_length_t  tlp_length
);
    import frag_pkg::*;

    logic         valid_nx;
    logic         sop_nx;
    logic         eop_nx;
    logic         put_ecrc;
    entry_t       data_nx;
    logic [2:0]   used_dw;
    valid_bytes_t vbytes_nx;

    assign valid_nx = beat.entry_valid || beat.tail;
    assign sop_nx   = beat.entry_valid && beat.first;
    assign eop_nx   = (beat.entry_valid && beat.last) || beat.tail;

    // ECRC fits in this beat only if a dword is left over
    assign put_ecrc = beat.entry_valid && beat.last && beat.ecrc_on && (fifo_rd_dw != 2'd3);

    always_comb begin
        data_nx = '0;
        if (beat.tail) begin
            data_nx[ENTRY_DW*DW_WIDTH-1 -: DW_WIDTH] = ecrc_value;
        end else begin
            for (int i = 0; i < ENTRY_DW; i++) begin
                if (i <= int'(fifo_rd_dw)) begin
                    data_nx[(ENTRY_DW-i)*DW_WIDTH-1 -: DW_WIDTH] =
                        fifo_rd_data[(ENTRY_DW-i)*DW_WIDTH-1 -: DW_WIDTH];
                end else if (put_ecrc && (i == int'(fifo_rd_dw) + 1)) begin
                    data_nx[(ENTRY_DW-i)*DW_WIDTH-1 -: DW_WIDTH] = ecrc_value;
                end
            end
        end
    end

    // Four bytes per used dword, minus one
    always_comb begin
        used_dw = {1'b0, fifo_rd_dw} + 3'd1 + {2'b00, put_ecrc};
        if (beat.tail) begin
            vbytes_nx = valid_bytes_t'(3);
        end else begin
            vbytes_nx = valid_bytes_t'({used_dw, 2'b00} - 5'd1);
        end
    end

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            tlp_valid <= 1'b0;
            tlp_sop   <= 1'b0;
            tlp_eop   <= 1'b0;
        end else begin
            tlp_valid <= valid_nx;
            tlp_sop   <= sop_nx;
            tlp_eop   <= eop_nx;
        end
    end

    // Payload only loads when a beat is produced
    always_ff @(posedge clk) begin
        if (valid_nx) begin
            tlp_data        <= data_nx;
            tlp_valid_bytes <= vbytes_nx;
            tlp_length      <= beat.length;
        end
    end

endmodule

//--- verilog/tlp_frag_top.sv
// Top level of the PCIe transmit fragmenter.
// Reads TLP entries from an external FIFO and sends 128-bit beats to
// the DLL with sop, eop, valid-byte count and packet length, adding
// the ECRC for TD packets. A read in one cycle gives its beat two
// cycles later; halt only holds off new reads.

`timescale 1ns/1ns

module tlp_frag_top (
    input  logic                   clk,
    input  logic                   arst,
    input  logic                   fifo_empty,
    input  frag_pkg::entry_t       fifo_rd_data,
    input  frag_pkg::dw_count_t    fifo_rd_dw,
    input  logic                   fifo_rd_last,
    input  logic                   halt,
    output logic                   fifo_rd_en,
    output logic                   tlp_valid,
    output logic                   tlp_sop,
    output logic                   tlp_eop,
    output frag_pkg::entry_t       tlp_data,
    output frag_pkg::valid_bytes_t tlp_valid_bytes,
    output frag_pkg::dll_length_t  tlp_length
);
    import frag_pkg::*;

    dword_t ecrc_value;

    frag_beat_if beat_if ();

    frag_sequencer seq_i (
        .clk          (clk),
        .arst         (arst),
        .fifo_empty   (fifo_empty),
        .halt         (halt),
        .fifo_rd_data (fifo_rd_data),
        .fifo_rd_dw   (fifo_rd_dw),
        .fifo_rd_last (fifo_rd_last),
        .fifo_rd_en   (fifo_rd_en),
        .beat         (beat_if.seq)
    );

    ecrc_engine ecrc_i (
        .clk          (clk),
        .arst         (arst),
        .fifo_rd_data (fifo_rd_data),
        .fifo_rd_dw   (fifo_rd_dw),
        .beat         (beat_if.ecrc),
        .ecrc_value   (ecrc_value)
    );

    beat_assembler asm_i (
        .clk             (clk),
        .arst            (arst),
        .fifo_rd_data    (fifo_rd_data),
        .fifo_rd_dw      (fifo_rd_dw),
        .beat            (beat_if.asm),
        .ecrc_value      (ecrc_value),
        .tlp_valid       (tlp_valid),
        .tlp_sop         (tlp_sop),
        .tlp_eop         (tlp_eop),
        .tlp_data        (tlp_data),
        .tlp_valid_bytes (tlp_valid_bytes),
        .tlp_length      (tlp_length)
    );

endmodule

//--- dv/tlp_frag_tb.sv
// Testbench for the PCIe transmit fragmenter.
// Turns a table of packets into FIFO entries and serves them from a
// FIFO model that answers reads one cycle later, with a halt pattern
// per packet. Every DLL beat is checked against beats built here,
// including a local CRC-32 for the ECRC.

`timescale 1ns/1ns

module tlp_frag_tb;
    import frag_pkg::*;

    localparam int NUM_ROWS     = 13;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

    typedef struct packed {
        logic [1:0] fmt;
        logic       td;
        logic [9:0] len;
        logic [7:0] halt_pat;
    } pkt_row_t;

    typedef struct packed {
        entry_t       data;
        logic         sop;
        logic         eop;
        valid_bytes_t vbytes;
        dll_length_t  length;
    } beat_t;

    logic         clk = 1'b0;
    logic         arst;
    logic         fifo_empty;
    entry_t       fifo_rd_data;
    dw_count_t    fifo_rd_dw;
    logic         fifo_rd_last;
    logic         halt;
    logic         fifo_rd_en;
    logic         tlp_valid;
    logic         tlp_sop;
    logic         tlp_eop;
    entry_t       tlp_data;
    valid_bytes_t tlp_valid_bytes;
    dll_length_t  tlp_length;

    pkt_row_t   rows [NUM_ROWS];
    entry_t     fifo_data_q [$];
    dw_count_t  fifo_dw_q [$];
    logic       fifo_last_q [$];
    logic [7:0] fifo_hpat_q [$];
    beat_t      exp_q [$];

    logic [2:0] phase = 3'd0;
    int mismatches    = 0;
    int other_errors  = 0;
    int beats_checked = 0;
    int wd_cycles     = 0;

    always #20 clk = ~clk;

    tlp_frag_top dut_i (
        .clk             (clk),
        .arst            (arst),
        .fifo_empty      (fifo_empty),
        .fifo_rd_data    (fifo_rd_data),
        .fifo_rd_dw      (fifo_rd_dw),
        .fifo_rd_last    (fifo_rd_last),
        .halt            (halt),
        .fifo_rd_en      (fifo_rd_en),
        .tlp_valid       (tlp_valid),
        .tlp_sop         (tlp_sop),
        .tlp_eop         (tlp_eop),
        .tlp_data        (tlp_data),
        .tlp_valid_bytes (tlp_valid_bytes),
        .tlp_length      (tlp_length)
    );

    task automatic load_table();
        // fmt, TD, length field, halt pattern
        rows[0]  = '{2'b00, 1'b0, 10'd16, 8'h00};
        rows[1]  = '{2'b01, 1'b0, 10'd0,  8'h00};
        rows[2]  = '{2'b10, 1'b0, 10'd1,  8'h00};
        rows[3]  = '{2'b10, 1'b0, 10'd2,  8'h00};
        rows[4]  = '{2'b11, 1'b0, 10'd2,  8'h24};
        rows[5]  = '{2'b00, 1'b1, 10'd0,  8'h00};
        rows[6]  = '{2'b01, 1'b1, 10'd0,  8'h00};
        rows[7]  = '{2'b11, 1'b1, 10'd5,  8'h00};
        rows[8]  = '{2'b10, 1'b1, 10'd3,  8'h81};
        rows[9]  = '{2'b10, 1'b1, 10'd4,  8'h00};
        rows[10] = '{2'b11, 1'b1, 10'd4,  8'hA5};
        rows[11] = '{2'b10, 1'b1, 10'd13, 8'h5A};
        rows[12] = '{2'b11, 1'b0, 10'd9,  8'h33};
    endtask

    // Non-reflected CRC-32 step over one dword taken MSB first
    function automatic logic [31:0] crc_fold(input logic [31:0] acc, input logic [31:0] word);
        logic [31:0] r;
        logic [31:0] w;
        logic        top;
        r = acc;
        w = word;
        for (int k = 0; k < 32; k++) begin
            top = r[31] ^ w[31];
            r   = {r[30:0], 1'b0} ^ (top ? CRC_POLY : 32'h0);
            w   = {w[30:0], 1'b0};
        end
        return r;
    endfunction

    task automatic add_packet(input pkt_row_t row, output int n_ent);
        dword_t dws [$];
        dword_t dw0;
        dword_t crc;
        int     hdr;
        int     ndata;
        int     total;
        int     cnt;
        logic   last;
        logic   crc_here;
        entry_t ent;
        beat_t  b;
        dw0        = '0;
        dw0[30:29] = row.fmt;
        dw0[15]    = row.td;
        dw0[9:0]   = row.len;
        hdr        = row.fmt[0] ? 4 : 3;
        ndata      = 0;
        if (row.fmt[1]) begin
            ndata = (row.len == '0) ? 1024 : int'(row.len);
        end
        dws.push_back(dw0);
        for (int i = 1; i < hdr + ndata; i++) begin
            dws.push_back($urandom);
        end
        total = dws.size();
        n_ent = (total + 3) / 4;
        crc   = 32'hFFFF_FFFF;
        foreach (dws[i]) begin
            crc = crc_fold(crc, dws[i]);
        end
        crc = ~crc;
        cnt = 0;
        b.length = dll_length_t'(total + (row.td ? 1 : 0));
        for (int e = 0; e < n_ent; e++) begin
            last     = (e == n_ent - 1);
            cnt      = last ? total - 4 * e : 4;
            crc_here = last && row.td && (cnt < 4);
            ent      = '0;
            b.data   = '0;
            for (int k = 0; k < 4; k++) begin
                if (k < cnt) begin
                    ent    = {ent[95:0], dws[4 * e + k]};
                    b.data = {b.data[95:0], dws[4 * e + k]};
                end else begin
                    // Unused FIFO dwords carry junk that the beat must zero
                    ent    = {ent[95:0], dword_t'($urandom)};
                    b.data = {b.data[95:0], (crc_here && k == cnt) ? crc : 32'h0};
                end
            end
            b.sop    = (e == 0);
            b.eop    = last;
            b.vbytes = valid_bytes_t'(4 * (crc_here ? cnt + 1 : cnt) - 1);
            fifo_data_q.push_back(ent);
            fifo_dw_q.push_back(dw_count_t'(cnt - 1));
            fifo_last_q.push_back(last);
            fifo_hpat_q.push_back(row.halt_pat);
            exp_q.push_back(b);
        end
        // Full last entry pushes the ECRC into a beat of its own
        if (row.td && cnt == 4) begin
            b.data   = {crc, 96'h0};
            b.sop    = 1'b0;
            b.eop    = 1'b1;
            b.vbytes = valid_bytes_t'(3);
            exp_q.push_back(b);
        end
    endtask

    task automatic compare_field(input string name, input logic [127:0] exp_val,
                                 input logic [127:0] act_val);
        assert (act_val === exp_val) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s expected %0h, got %0h",
                     $time, name, exp_val, act_val);
        end
    endtask

    task automatic check_beat();
        beat_t e;
        if (tlp_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                other_errors++;
                $display("ERROR at %0t ns: a beat arrived when none was expected", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                beats_checked++;
                compare_field("tlp_sop", 128'(e.sop), 128'(tlp_sop));
                compare_field("tlp_eop", 128'(e.eop), 128'(tlp_eop));
                compare_field("tlp_data", e.data, tlp_data);
                compare_field("tlp_valid_bytes", 128'(e.vbytes), 128'(tlp_valid_bytes));
                compare_field("tlp_length", 128'(e.length), 128'(tlp_length));
            end
        end
    endtask

    // FIFO model answers a read in the following cycle
    task automatic drive_fifo(input logic rd);
        if (rd && fifo_data_q.size() != 0) begin
            fifo_rd_data = fifo_data_q.pop_front();
            fifo_rd_dw   = fifo_dw_q.pop_front();
            fifo_rd_last = fifo_last_q.pop_front();
            fifo_hpat_q.delete(0);
        end else begin
            fifo_rd_data = '0;
            fifo_rd_dw   = '0;
            fifo_rd_last = 1'b0;
        end
        fifo_empty = (fifo_data_q.size() == 0);
        halt       = (fifo_hpat_q.size() != 0) ? fifo_hpat_q[0][phase] : 1'b0;
        phase      = phase + 3'd1;
    endtask

    task automatic print_counts();
        $display("Summary: %0d beats checked, %0d mismatches, %0d other errors",
                 beats_checked, mismatches, other_errors);
    endtask

    initial begin : main
        logic       rd_seen;
        logic [1:0] rd_hist;
        int         limit;
        int         n_ent;
        arst         = 1'b0;
        fifo_empty   = 1'b1;
        fifo_rd_data = '0;
        fifo_rd_dw   = '0;
        fifo_rd_last = 1'b0;
        halt         = 1'b0;
        void'($urandom(40501));
        load_table();
        limit = RESET_CYCLES + IDLE_CYCLES;
        for (int r = 0; r < NUM_ROWS; r++) begin
            add_packet(rows[r], n_ent);
            limit = limit + 3 * n_ent + 10;
        end
        wd_cycles = limit;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst = 1'b1;

        // Nothing may move while the FIFO reports empty
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            compare_field("fifo_rd_en", 128'(0), 128'(fifo_rd_en));
            compare_field("tlp_valid", 128'(0), 128'(tlp_valid));
            compare_field("tlp_sop", 128'(0), 128'(tlp_sop));
            compare_field("tlp_eop", 128'(0), 128'(tlp_eop));
        end
        #2;
        drive_fifo(1'b0);
        rd_hist = 2'b00;

        while (exp_q.size() != 0) begin
            @(posedge clk);
            rd_seen = fifo_rd_en;
            if (rd_seen) begin
                assert (!halt && !fifo_empty) else begin
                    other_errors++;
                    $display("ERROR at %0t ns: FIFO read while halt or fifo_empty is high",
                             $time);
                end
            end
            // Each read shows up as a beat two cycles later
            assert (!rd_hist[1] || tlp_valid === 1'b1) else begin
                other_errors++;
                $display("ERROR at %0t ns: no beat two cycles after a FIFO read", $time);
            end
            rd_hist = {rd_hist[0], rd_seen};
            check_beat();
            #2;
            drive_fifo(rd_seen);
        end
        // A few more cycles to catch extra beats
        repeat (4) begin
            @(posedge clk);
            check_beat();
        end
        assert (fifo_data_q.size() == 0) else begin
            other_errors++;
            $display("ERROR: %0d FIFO entries were never read", fifo_data_q.size());
        end

        print_counts();
        if (mismatches + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: run passed %0d clock cycles with %0d beats still outstanding",
                 wd_cycles, exp_q.size());
        print_counts();
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- flist.f
verilog/frag_pkg.sv
verilog/frag_beat_if.sv
verilog/frag_sequencer.sv
verilog/ecrc_engine.sv
verilog/beat_assembler.sv
verilog/tlp_frag_top.sv
dv/tlp_frag_tb.sv

//--- Makefile
# Verilator build and run for the TLP fragmenter testbench

TOP := tlp_frag_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
